//--- math_params.svh
`ifndef MATH_PARAMS_SVH
`define MATH_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// adder geometry
////////////////////////////////////////////////////////////////////////////

// width of one adder slice, matches a DSP post-adder
`define MATH_SLICE_W 48

// full operand width, two slices side by side
`define MATH_WORD_W (2 * `MATH_SLICE_W)

////////////////////////////////////////////////////////////////////////////
// pipeline
////////////////////////////////////////////////////////////////////////////

// enabled edges from operands in to sum out
`define MATH_ADD_LAT 3

`endif

//--- math_pkg.sv
`include "math_params.svh"

package math_pkg;

  //////////////////////////////////////////////////////////////////////////
  // data words
  //////////////////////////////////////////////////////////////////////////

  // one slice worth of unsigned data
  typedef logic [`MATH_SLICE_W-1:0] word48_t;

  // a full operand
  typedef logic [`MATH_WORD_W-1:0] word96_t;

  // full sum, top bit is the carry-out
  typedef logic [`MATH_WORD_W:0] sum97_t;

  //////////////////////////////////////////////////////////////////////////
  // grouped payloads
  //////////////////////////////////////////////////////////////////////////

  // upper halves of both operands, skewed together through one delay line
  typedef struct packed {
    word48_t a;
    word48_t b;
  } operand_pair_t;

endpackage

//--- shift_reg.sv
`timescale 1ns/100ps

module shift_reg import math_pkg::*; #(
  parameter type data_t = word48_t,
  parameter int  DEPTH  = 1
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  ena,

  // payload in and out
  input  data_t din,
  output data_t dout
);

  ////////////////////////////////////////////////////////////////////////////
  // register chain
  ////////////////////////////////////////////////////////////////////////////

  // stage 0 is the input end
  data_t stage_q [DEPTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else if (ena) begin
      stage_q[0] <= din;
      // shift toward the output, no-op when DEPTH is 1
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // last stage drives the output
  assign dout = stage_q[DEPTH-1];

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // once out of reset, an X here means an upstream block never got cleared
  a_dout_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(dout)
  ) else $error("shift_reg: unknown bits on dout after reset");

endmodule

//--- math_add_48.sv
`timescale 1ns/100ps

`include "math_params.svh"

module math_adder_slice import math_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    ena,

  // operands
  input  word48_t a,
  input  word48_t b,

  // carry from the slice below enters at the sum stage
  input  logic    carry_in,

  // registered result
  output word48_t sum,
  output logic    carry_out
);

  ////////////////////////////////////////////////////////////////////////////
  // stage 1 operand registers
  ////////////////////////////////////////////////////////////////////////////

  word48_t a_q;
  word48_t b_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a_q <= '0;
      b_q <= '0;
    end else if (ena) begin
      a_q <= a;
      b_q <= b;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2 post-adder and sum register
  ////////////////////////////////////////////////////////////////////////////

  // one extra bit holds the carry-out
  logic [`MATH_SLICE_W:0] sum_next;
  logic [`MATH_SLICE_W:0] sum_q;

  // same job as the DSP post-adder with A:B plus C
  assign sum_next = {1'b0, a_q}
                  + {1'b0, b_q}
                  + {{`MATH_SLICE_W{1'b0}}, carry_in};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_q <= '0;
    end else if (ena) begin
      sum_q <= sum_next;
    end
  end

  // split the register into sum and carry
  assign sum       = sum_q[`MATH_SLICE_W-1:0];
  assign carry_out = sum_q[`MATH_SLICE_W];

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // an X captured here would spread into every later sum
  a_in_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    ena |-> !$isunknown({a, b, carry_in})
  ) else $error("math_adder_slice: unknown operand or carry captured");

endmodule

//--- math_add_96.sv
`timescale 1ns/100ps

`include "math_params.svh"

module math_add_96 import math_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    ena,

  // operands
  input  word96_t dina,
  input  word96_t dinb,

  // sum with the carry-out in bit 96
  output sum97_t  dout
);

  ////////////////////////////////////////////////////////////////////////////
  // pipeline budget
  ////////////////////////////////////////////////////////////////////////////

  // operand reg plus sum reg inside each slice
  localparam int SLICE_LAT = 2;

  // skew stages needed so both paths total the full latency
  localparam int DLY_DEPTH = `MATH_ADD_LAT - SLICE_LAT;

  ////////////////////////////////////////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////////////////////////////////////////

  // lower slice
  word48_t       sum_l;
  logic          carry_l;

  // upper operands before and after the skew
  operand_pair_t ops_hi;
  operand_pair_t ops_hi_d;

  assign ops_hi.a = dina[`MATH_WORD_W-1:`MATH_SLICE_W];
  assign ops_hi.b = dinb[`MATH_WORD_W-1:`MATH_SLICE_W];

  ////////////////////////////////////////////////////////////////////////////
  // lower half
  ////////////////////////////////////////////////////////////////////////////

  // produces bits 47:0 and the carry into the upper half
  // bottom slice has nothing below it
  math_adder_slice u_add_l (
    .clk       (clk),
    .rst_n     (rst_n),
    .ena       (ena),
    .a         (dina[`MATH_SLICE_W-1:0]),
    .b         (dinb[`MATH_SLICE_W-1:0]),
    .carry_in  (1'b0),
    .sum       (sum_l),
    .carry_out (carry_l)
  );

  // hold the lower sum while the upper half catches up
  shift_reg #(
    .data_t (word48_t),
    .DEPTH  (DLY_DEPTH)
  ) u_dly_lo (
    .clk   (clk),
    .rst_n (rst_n),
    .ena   (ena),
    .din   (sum_l),
    .dout  (dout[`MATH_SLICE_W-1:0])
  );

  ////////////////////////////////////////////////////////////////////////////
  // upper half
  ////////////////////////////////////////////////////////////////////////////

  // delay upper operands one stage so carry_l lands at their sum stage
  shift_reg #(
    .data_t (operand_pair_t),
    .DEPTH  (DLY_DEPTH)
  ) u_dly_hi (
    .clk   (clk),
    .rst_n (rst_n),
    .ena   (ena),
    .din   (ops_hi),
    .dout  (ops_hi_d)
  );

  // carry out of this slice is the carry out of the whole add
  math_adder_slice u_add_u (
    .clk       (clk),
    .rst_n     (rst_n),
    .ena       (ena),
    .a         (ops_hi_d.a),
    .b         (ops_hi_d.b),
    .carry_in  (carry_l),
    .sum       (dout[`MATH_WORD_W-1:`MATH_SLICE_W]),
    .carry_out (dout[`MATH_WORD_W])
  );

endmodule

//--- tb_math_add_96.sv
`timescale 1ns/100ps

`include "math_params.svh"

module tb_math_add_96 import math_pkg::*; ();

  ////////////////////////////////////////////////////////////////////////////
  // run length
  ////////////////////////////////////////////////////////////////////////////

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYC    = 3;
  localparam int N_STREAM     = 200;
  localparam int N_BOUNDARY   = 24;
  localparam int N_CARRY_OUT  = 32;
  localparam int N_STALL      = 200;
  localparam int FLUSH_CYC    = `MATH_ADD_LAT + 1;
  localparam int TOTAL_CYCLES = RESET_CYC + 4 + N_STREAM + N_BOUNDARY + N_CARRY_OUT
                              + N_STALL + 5 * FLUSH_CYC;
  localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 50) * CLK_PERIOD;

  localparam logic [31:0] LFSR_SEED = 32'd87098;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    ena;
  word96_t dina;
  word96_t dinb;
  sum97_t  dout;

  int          check_count;
  int          error_count;
  logic [31:0] lfsr_state;

  // expected results in flight with one entry per enabled edge
  sum97_t exp_q [$];
  sum97_t exp_dout;
  logic   model_live = 1'b0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  math_add_96 u_math_add_96 (
    .clk   (clk),
    .rst_n (rst_n),
    .ena   (ena),
    .dina  (dina),
    .dinb  (dinb),
    .dout  (dout)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output word96_t w);
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[`MATH_WORD_W-2:0], lfsr_state[0]};
    end
  endtask

  // plain unsigned add with one extra bit for the carry-out
  function automatic sum97_t ref_sum(input word96_t a, input word96_t b);
    return {1'b0, a} + {1'b0, b};
  endfunction

  task automatic check_value(input string name, input sum97_t expected, input sum97_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
    end
  endtask

  task automatic apply(input logic e, input word96_t a, input word96_t b);
    @(negedge clk);
    ena  = e;
    dina = a;
    dinb = b;
  endtask

  // push the last pairs of a test out to dout
  task automatic flush();
    repeat (FLUSH_CYC) apply(1'b1, '0, '0);
  endtask

  task automatic report_test(input string name, input int c0, input int e0);
    $display("test %s: %0d checks, %0d errors", name, check_count - c0, error_count - e0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model and compare
  ////////////////////////////////////////////////////////////////////////////

  // zeros fill the pipe so dout reads 0 until the first pair lands
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_q.delete();
      for (int i = 0; i < `MATH_ADD_LAT - 1; i++) begin
        exp_q.push_back('0);
      end
      exp_dout   = '0;
      model_live = 1'b0;
    end else begin
      model_live = 1'b1;
      if (ena) begin
        exp_q.push_back(ref_sum(dina, dinb));
        exp_dout = exp_q.pop_front();
      end
    end
  end

  // dout only moves on rising edges so the falling edge is a quiet place to look
  // a stalled edge leaves exp_dout alone and any change in dout shows up here
  always @(negedge clk) begin
    if (model_live) begin
      check_value("dout", exp_dout, dout);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int      c0;
    int      e0;
    word96_t a;
    word96_t b;
    word96_t w;
    word96_t kw;

    rst_n       = 1'b0;
    ena         = 1'b0;
    dina        = '0;
    dinb        = '0;
    check_count = 0;
    error_count = 0;
    lfsr_state  = LFSR_SEED;

    repeat (RESET_CYC) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // reset leaves zeros until the first pair has had three edges
    c0 = check_count;
    e0 = error_count;
    check_value("dout", '0, dout);
    draw_bits(`MATH_WORD_W, a);
    draw_bits(`MATH_WORD_W, b);
    apply(1'b1, a, b);
    draw_bits(`MATH_WORD_W, a);
    draw_bits(`MATH_WORD_W, b);
    apply(1'b1, a, b);
    check_value("dout", '0, dout);
    @(negedge clk);
    check_value("dout", '0, dout);
    flush();
    report_test("reset", c0, e0);

    // back to back random pairs
    c0 = check_count;
    e0 = error_count;
    for (int i = 0; i < N_STREAM; i++) begin
      draw_bits(`MATH_WORD_W, a);
      draw_bits(`MATH_WORD_W, b);
      apply(1'b1, a, b);
    end
    flush();
    report_test("random_stream", c0, e0);

    // carry from the lower slice into the upper one
    c0 = check_count;
    e0 = error_count;
    for (int i = 0; i < N_BOUNDARY; i++) begin
      draw_bits(`MATH_WORD_W, w);
      case (i)
        0: begin
          a = {48'h0, 48'hFFFF_FFFF_FFFF};
          b = 96'd1;
        end
        1: begin
          a = {`MATH_WORD_W{1'b1}};
          b = 96'd1;
        end
        2: begin
          a = {48'h0, 48'hFFFF_FFFF_FFFF};
          b = {48'h0, 48'hFFFF_FFFF_FFFF};
        end
        3: begin
          a = {48'hFFFF_FFFF_FFFE, 48'hFFFF_FFFF_FFFF};
          b = 96'd1;
        end
        4: begin
          a = {w[47:0], 48'h8000_0000_0000};
          b = {w[95:48], 48'h8000_0000_0000};
        end
        default: begin
          // random upper half with the lower half primed to carry
          a = {w[95:48], 48'hFFFF_FFFF_FFFF};
          b = {w[47:0], w[95:48]};
        end
      endcase
      apply(1'b1, a, b);
    end
    flush();
    report_test("carry_boundary", c0, e0);

    // sums just below 2^96 alternating with sums exactly on it
    c0 = check_count;
    e0 = error_count;
    for (int i = 0; i < N_CARRY_OUT; i++) begin
      kw = word96_t'(i / 2);
      a  = {`MATH_WORD_W{1'b1}} - kw;
      b  = kw + word96_t'(i % 2);
      apply(1'b1, a, b);
    end
    flush();
    report_test("carry_out", c0, e0);

    // random gaps in ena while the inputs keep changing
    c0 = check_count;
    e0 = error_count;
    for (int i = 0; i < N_STALL; i++) begin
      draw_bits(2, w);
      draw_bits(`MATH_WORD_W, a);
      draw_bits(`MATH_WORD_W, b);
      if (w[1:0] == 2'b00) begin
        apply(1'b0, a, b);
      end else begin
        apply(1'b1, a, b);
      end
    end
    flush();
    report_test("enable_stall", c0, e0);

    $display("summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- math_add_96.f
+incdir+.
math_pkg.sv
shift_reg.sv
math_add_48.sv
math_add_96.sv
tb_math_add_96.sv

//--- run_sim.sh
#!/bin/sh
# build and run the math_add_96 testbench with Verilator
# exit status is 0 on pass, 1 on fail

cd "$(dirname "$0")" || exit 1

TOP=tb_math_add_96
FLIST=math_add_96.f
BUILD_LOG=build.log
SIM_LOG=sim.log
FAIL_MSG="Simulation failed"

# compile
verilator --binary --timing --assert -j 0 \
  --top-module "$TOP" \
  -f "$FLIST" \
  -o "V$TOP" > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed with status $status"
  exit 1
fi

# run
"./obj_dir/V$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# verdict from the log
if grep -q "$FAIL_MSG" "$SIM_LOG"; then
  echo "FAIL: see $SIM_LOG"
  exit 1
fi

if ! grep -q "Simulation completed successfully" "$SIM_LOG"; then
  echo "FAIL: run ended without a result line, see $SIM_LOG"
  exit 1
fi

echo "PASS"
exit 0
